/* compile.f */
logic/arp_pkg.sv
logic/arp_entry_ram.sv
logic/arp_rx_filter.sv
logic/arp_tx_serializer.sv
logic/arp_table.sv
logic/arp_top.sv
verification/arp_props.sv
verification/tb_arp.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_arp -f compile.f -o tb_arp

out=$(./obj_dir/tb_arp || true)
echo "$out"

# status comes from the pass line
echo "$out" | grep -qx "Testbench passed"

/* verification/tb_arp.sv */
`timescale 1ns/1ns

module tb_arp;

  import arp_pkg::*;

  localparam int ADDR_W        = 2;
  localparam int TIMEOUT_TICKS = 200;
  localparam int NUM_ROWS      = 21;
  localparam int IDLE_CYCLES   = 20;

  typedef enum logic [2:0] {
    OP_LEARN, OP_BAD_HLEN, OP_BAD_DST, OP_BAD_OPER, OP_LOOKUP, OP_LOOKUP_REPLY
  } op_t;

  typedef enum logic [1:0] {EXP_NONE, EXP_HIT, EXP_REPLY, EXP_ERR} exp_t;

  typedef struct packed {
    op_t   op;
    ipv4_t ip;
    mac_t  mac;  // learned, hit or reply mac
    exp_t  exp;
  } row_t;

  logic       clk;
  logic       rst;
  dev_t       dev;
  arp_hdr_t   rx_hdr;
  logic       rx_hdr_val;
  logic       lookup_req;
  ipv4_t      lookup_ipv4;
  logic       rsp_val;
  logic       rsp_err;
  mac_t       rsp_mac;
  logic [7:0] tx_data;
  logic       tx_val;
  logic       tx_last;

  row_t        rows [NUM_ROWS];
  logic [7:0]  tx_bytes [$];
  mac_t        ref_mac [logic [31:0]];  // expected bindings by ip
  logic [31:0] slot_ip [2**ADDR_W];
  logic        slot_used [2**ADDR_W];
  int          wr_ptr;

  arp_top #(
    .ADDR_W        (ADDR_W),
    .TIMEOUT_TICKS (TIMEOUT_TICKS)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_equal(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic arp_hdr_t make_hdr(input logic [7:0] hlen, input logic [15:0] oper,
                                        input mac_t src_mac, input ipv4_t src_ip,
                                        input ipv4_t dst_ip);
    arp_hdr_t h;
    h = {16'h0001, 16'h0800, hlen, 8'h04, oper, src_mac, src_ip, dev.mac, dst_ip};
    return h;
  endfunction

  task automatic send_hdr(input arp_hdr_t h);
    step();
    rx_hdr     = h;
    rx_hdr_val = 1'b1;
    step();
    rx_hdr_val = 1'b0;
  endtask

  task automatic model_learn(input ipv4_t ip, input mac_t mac);
    if (!ref_mac.exists(ip)) begin
      if (slot_used[wr_ptr]) begin
        ref_mac.delete(slot_ip[wr_ptr]);  // oldest insertion goes
      end
      slot_ip[wr_ptr]   = ip;
      slot_used[wr_ptr] = 1'b1;
      wr_ptr = (wr_ptr + 1) % (2**ADDR_W);
    end
    ref_mac[ip] = mac;
  endtask

  task automatic wait_frame(input int first);
    int n;
    n = 0;
    while (tx_bytes.size() < first + ARP_HDR_BYTES) begin
      @(negedge clk);
      n++;
      if (n > 100) abort_run("request frame did not appear after a lookup miss");
    end
  endtask

  task automatic wait_rsp();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT_TICKS + 100) abort_run("lookup got neither rsp_val nor rsp_err");
    end while (!rsp_val && !rsp_err);
  endtask

  task automatic do_lookup(input row_t r);
    int           first;
    logic         hit;
    logic [223:0] req;
    hit = ref_mac.exists(r.ip);
    check_equal("model hit", hit, r.exp == EXP_HIT);
    if (hit) check_equal("model mac", ref_mac[r.ip], r.mac);
    first = tx_bytes.size();
    step();
    lookup_req  = 1'b1;
    lookup_ipv4 = r.ip;
    step();
    lookup_req = 1'b0;
    if (r.exp == EXP_REPLY) begin
      wait_frame(first);
      send_hdr(make_hdr(8'h06, 16'h0002, r.mac, r.ip, dev.ipv4));
      model_learn(r.ip, r.mac);  // the reply is learned too
    end
    wait_rsp();
    check_equal("rsp_val", rsp_val, r.exp != EXP_ERR);
    check_equal("rsp_err", rsp_err, r.exp == EXP_ERR);
    if (rsp_val) check_equal("rsp_mac", rsp_mac, r.mac);
    check_equal("request byte count", tx_bytes.size() - first, hit ? 0 : ARP_HDR_BYTES);
    // broadcast request for the looked up ip
    req = {16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0001, dev.mac, dev.ipv4, {48{1'b1}}, r.ip};
    if (!hit) begin
      for (int i = 0; i < ARP_HDR_BYTES; i++) begin
        check_equal($sformatf("request byte %0d", i), tx_bytes[first+i], req[223-8*i -: 8]);
      end
    end
  endtask

  always @(posedge clk) begin
    if (tx_val) begin
      tx_bytes.push_back(tx_data);
      check_equal("tx_last", tx_last, tx_bytes.size() % ARP_HDR_BYTES == 0);
    end
  end

  always @(negedge clk) begin
    if (u_dut.u_props.fail_cnt != 0) abort_run("an assertion in arp_props failed");
  end

  initial begin
    #(NUM_ROWS * (TIMEOUT_TICKS + 100) * 10);
    abort_run("watchdog expired before all stimulus rows finished");
  end

  initial begin
    rst         = 1'b1;
    dev         = {48'h02_00_00_00_00_01, 32'hc0a8_010a};
    rx_hdr      = '0;
    rx_hdr_val  = 1'b0;
    lookup_req  = 1'b0;
    lookup_ipv4 = '0;
    wr_ptr      = 0;
    slot_used   = '{default: 1'b0};
    rows[0]  = '{OP_LEARN,        32'h0a000001, 48'h02aa00000001, EXP_NONE};
    rows[1]  = '{OP_LOOKUP,       32'h0a000001, 48'h02aa00000001, EXP_HIT};
    rows[2]  = '{OP_LOOKUP,       32'h0a000009, 48'h000000000000, EXP_ERR};
    rows[3]  = '{OP_LOOKUP_REPLY, 32'h0a000002, 48'h02bb00000002, EXP_REPLY};
    rows[4]  = '{OP_LOOKUP,       32'h0a000002, 48'h02bb00000002, EXP_HIT};
    rows[5]  = '{OP_LEARN,        32'h0a000001, 48'h02cc00000001, EXP_NONE};  // new mac
    rows[6]  = '{OP_LOOKUP,       32'h0a000001, 48'h02cc00000001, EXP_HIT};
    rows[7]  = '{OP_LEARN,        32'h0a000003, 48'h02aa00000003, EXP_NONE};
    rows[8]  = '{OP_LEARN,        32'h0a000004, 48'h02aa00000004, EXP_NONE};
    rows[9]  = '{OP_LEARN,        32'h0a000005, 48'h02aa00000005, EXP_NONE};  // evicts .1
    rows[10] = '{OP_LOOKUP,       32'h0a000001, 48'h000000000000, EXP_ERR};
    rows[11] = '{OP_LOOKUP,       32'h0a000002, 48'h02bb00000002, EXP_HIT};
    rows[12] = '{OP_LOOKUP,       32'h0a000003, 48'h02aa00000003, EXP_HIT};
    rows[13] = '{OP_LOOKUP,       32'h0a000004, 48'h02aa00000004, EXP_HIT};
    rows[14] = '{OP_LOOKUP,       32'h0a000005, 48'h02aa00000005, EXP_HIT};
    rows[15] = '{OP_BAD_HLEN,     32'h0a000006, 48'h02dd00000006, EXP_NONE};
    rows[16] = '{OP_BAD_DST,      32'h0a000007, 48'h02dd00000007, EXP_NONE};
    rows[17] = '{OP_BAD_OPER,     32'h0a000008, 48'h02dd00000008, EXP_NONE};
    rows[18] = '{OP_LOOKUP,       32'h0a000006, 48'h000000000000, EXP_ERR};
    rows[19] = '{OP_LOOKUP,       32'h0a000007, 48'h000000000000, EXP_ERR};
    rows[20] = '{OP_LOOKUP,       32'h0a000008, 48'h000000000000, EXP_ERR};
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (10) step();  // table clear sweep
    foreach (rows[i]) begin
      case (rows[i].op)
        OP_LOOKUP, OP_LOOKUP_REPLY: do_lookup(rows[i]);
        OP_LEARN: begin
          send_hdr(make_hdr(8'h06, 16'h0001, rows[i].mac, rows[i].ip, dev.ipv4));
          model_learn(rows[i].ip, rows[i].mac);
        end
        OP_BAD_HLEN: send_hdr(make_hdr(8'h05, 16'h0001, rows[i].mac, rows[i].ip, dev.ipv4));
        OP_BAD_DST: send_hdr(make_hdr(8'h06, 16'h0001, rows[i].mac, rows[i].ip, dev.ipv4 + 1));
        default: send_hdr(make_hdr(8'h06, 16'h0003, rows[i].mac, rows[i].ip, dev.ipv4));
      endcase
      repeat (IDLE_CYCLES) step();
    end
    if (u_dut.u_props.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_arp

/* verification/arp_props.sv */
`timescale 1ns/1ns

module arp_props (
  input logic clk,
  input logic rst,
  input logic rsp_val,
  input logic rsp_err,
  input logic tx_val,
  input logic tx_last
);

  int         fail_cnt = 0;
  logic [5:0] run;  // tx_val cycles so far in this frame

  always_ff @(posedge clk) begin
    if (rst || !tx_val) begin
      run <= '0;
    end else begin
      run <= run + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(rsp_val && rsp_err))
    else begin $error("rsp_val and rsp_err high together"); fail_cnt++; end

  assert property (@(posedge clk) disable iff (rst) tx_last |-> tx_val)
    else begin $error("tx_last without tx_val"); fail_cnt++; end

  assert property (@(posedge clk) disable iff (rst) rsp_val |=> !rsp_val)
    else begin $error("rsp_val longer than one cycle"); fail_cnt++; end

  // frame is exactly 28 bytes long
  assert property (@(posedge clk) disable iff (rst) tx_val |-> run < 6'd28)
    else begin $error("tx_val frame longer than 28 cycles"); fail_cnt++; end

  assert property (@(posedge clk) disable iff (rst) (!tx_val && run != '0) |-> run == 6'd28)
    else begin $error("tx_val frame shorter than 28 cycles"); fail_cnt++; end

endmodule : arp_props

bind arp_top arp_props u_props (
  .clk     (clk),
  .rst     (rst),
  .rsp_val (rsp_val),
  .rsp_err (rsp_err),
  .tx_val  (tx_val),
  .tx_last (tx_last)
);

/* logic/arp_top.sv */
`timescale 1ns/1ns

module arp_top #(
  parameter int ADDR_W        = 4,
  parameter int TIMEOUT_TICKS = 1000
) (
  input  logic              clk,
  input  logic              rst,
  input  arp_pkg::dev_t     dev,
  input  arp_pkg::arp_hdr_t rx_hdr,
  input  logic              rx_hdr_val,
  input  logic              lookup_req,
  input  arp_pkg::ipv4_t    lookup_ipv4,
  output logic              rsp_val,
  output logic              rsp_err,
  output arp_pkg::mac_t     rsp_mac,
  output logic [7:0]        tx_data,
  output logic              tx_val,
  output logic              tx_last
);

  import arp_pkg::*;

  logic              learn_val;
  arp_entry_t        learn_entry;
  arp_hdr_t          tx_hdr;
  logic              send_req;
  logic              tx_busy;

  // entry ram ports
  logic [ADDR_W-1:0] addr_a;
  logic              we_a;
  arp_entry_t        d_a;
  arp_entry_t        q_a;
  logic [ADDR_W-1:0] addr_b;
  arp_entry_t        q_b;

  arp_rx_filter u_rx_filter (
    .clk         (clk),
    .rst         (rst),
    .dev         (dev),
    .rx_hdr      (rx_hdr),
    .rx_hdr_val  (rx_hdr_val),
    .learn_val   (learn_val),
    .learn_entry (learn_entry)
  );

  arp_table #(
    .ADDR_W        (ADDR_W),
    .TIMEOUT_TICKS (TIMEOUT_TICKS)
  ) u_table (
    .clk         (clk),
    .rst         (rst),
    .dev         (dev),
    .learn_val   (learn_val),
    .learn_entry (learn_entry),
    .lookup_req  (lookup_req),
    .lookup_ipv4 (lookup_ipv4),
    .rsp_val     (rsp_val),
    .rsp_err     (rsp_err),
    .rsp_mac     (rsp_mac),
    .tx_hdr      (tx_hdr),
    .send_req    (send_req),
    .tx_busy     (tx_busy),
    .addr_a      (addr_a),
    .we_a        (we_a),
    .d_a         (d_a),
    .q_a         (q_a),
    .addr_b      (addr_b),
    .q_b         (q_b)
  );

  arp_entry_ram #(
    .ADDR_W (ADDR_W)
  ) u_entry_ram (
    .clk    (clk),
    .addr_a (addr_a),
    .we_a   (we_a),
    .d_a    (d_a),
    .q_a    (q_a),
    .addr_b (addr_b),
    .q_b    (q_b)
  );

  arp_tx_serializer u_tx_serializer (
    .clk      (clk),
    .rst      (rst),
    .tx_hdr   (tx_hdr),
    .send_req (send_req),
    .tx_busy  (tx_busy),
    .tx_data  (tx_data),
    .tx_val   (tx_val),
    .tx_last  (tx_last)
  );

endmodule : arp_top

/* logic/arp_table.sv */
`timescale 1ns/1ns

module arp_table #(
  parameter int ADDR_W        = 4,
  parameter int TIMEOUT_TICKS = 1000
) (
  input  logic                             clk,
  input  logic                             rst,
  input  arp_pkg::dev_t                    dev,
  input  logic                             learn_val,
  input  arp_pkg::arp_entry_t              learn_entry,
  input  logic                             lookup_req,
  input  arp_pkg::ipv4_t                   lookup_ipv4,
  output logic                             rsp_val,
  output logic                             rsp_err,
  output arp_pkg::mac_t                    rsp_mac,
  output arp_pkg::arp_hdr_t                tx_hdr,
  output logic                             send_req,
  input  logic                             tx_busy,
  output logic                [ADDR_W-1:0] addr_a,
  output logic                             we_a,
  output arp_pkg::arp_entry_t              d_a,
  input  arp_pkg::arp_entry_t              q_a,
  output logic                [ADDR_W-1:0] addr_b,
  input  arp_pkg::arp_entry_t              q_b
);

  import arp_pkg::*;

  localparam logic [ADDR_W:0] ENTRIES    = (ADDR_W+1)'(2**ADDR_W);
  localparam logic [ADDR_W:0] LAST_ENTRY = (ADDR_W+1)'(2**ADDR_W - 1);
  localparam int              TMR_W      = $clog2(TIMEOUT_TICKS + 1);
  localparam logic [TMR_W-1:0] TMR_LAST  = TMR_W'(TIMEOUT_TICKS - 1);

  typedef enum logic [2:0] {
    W_CLEAR,
    W_IDLE,
    W_SCAN,
    W_UPD,
    W_ADD
  } w_state_t;

  typedef enum logic [1:0] {
    R_IDLE,
    R_SCAN,
    R_SEND,
    R_WAIT
  } r_state_t;

  w_state_t          w_state;
  logic [ADDR_W:0]   w_cnt;     // clear index and then compare count
  logic [ADDR_W-1:0] w_ptr;     // round robin insert slot
  logic [ADDR_W-1:0] hit_addr;
  arp_entry_t        cur;       // entry being learned

  r_state_t          r_state;
  logic [ADDR_W:0]   r_cnt;
  ipv4_t             look_ip;
  logic [TMR_W-1:0]  tmr;

  // learn side on port a
  always_ff @(posedge clk) begin
    if (rst) begin
      w_state <= W_CLEAR;
      w_cnt   <= '0;
      w_ptr   <= '0;
      addr_a  <= '0;
      we_a    <= 1'b0;
    end else begin
      case (w_state)
        W_CLEAR: begin
          we_a   <= 1'b1;
          addr_a <= w_cnt[ADDR_W-1:0];
          d_a    <= '0;
          w_cnt  <= w_cnt + 1'b1;
          if (w_cnt == LAST_ENTRY) begin
            w_state <= W_IDLE;
          end
        end
        W_IDLE: begin
          we_a   <= 1'b0;
          addr_a <= '0;
          w_cnt  <= '0;
          if (learn_val) begin
            cur     <= learn_entry;
            w_state <= W_SCAN;
          end
        end
        W_SCAN: begin
          // q_a lags addr_a by one so the first compare is at w_cnt == 1
          w_cnt  <= w_cnt + 1'b1;
          addr_a <= addr_a + 1'b1;
          if (w_cnt != '0 && q_a.valid && q_a.ipv4 == cur.ipv4) begin
            hit_addr <= w_cnt[ADDR_W-1:0] - 1'b1;
            w_state  <= W_UPD;
          end else if (w_cnt == ENTRIES) begin
            w_state <= W_ADD;
          end
        end
        W_UPD: begin
          addr_a  <= hit_addr;  // overwrite in place
          d_a     <= cur;
          we_a    <= 1'b1;
          w_state <= W_IDLE;
        end
        W_ADD: begin
          addr_a  <= w_ptr;     // evicts oldest insertion
          d_a     <= cur;
          we_a    <= 1'b1;
          w_ptr   <= w_ptr + 1'b1;
          w_state <= W_IDLE;
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  // lookup side on port b
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state  <= R_IDLE;
      r_cnt    <= '0;
      addr_b   <= '0;
      tmr      <= '0;
      rsp_val  <= 1'b0;
      rsp_err  <= 1'b0;
      send_req <= 1'b0;
    end else begin
      rsp_val  <= 1'b0;
      rsp_err  <= 1'b0;
      send_req <= 1'b0;
      case (r_state)
        R_IDLE: begin
          addr_b <= '0;
          r_cnt  <= '0;
          tmr    <= '0;
          if (lookup_req) begin
            look_ip <= lookup_ipv4;
            r_state <= R_SCAN;
          end
        end
        R_SCAN: begin
          r_cnt  <= r_cnt + 1'b1;
          addr_b <= addr_b + 1'b1;
          if (r_cnt != '0 && q_b.valid && q_b.ipv4 == look_ip) begin
            rsp_mac <= q_b.mac;
            rsp_val <= 1'b1;
            r_state <= R_IDLE;
          end else if (r_cnt == ENTRIES) begin
            // no match so build a broadcast request
            tx_hdr.hw_type  <= ARP_HW_ETH;
            tx_hdr.proto    <= ARP_PROTO_IPV4;
            tx_hdr.hlen     <= ARP_HLEN_ETH;
            tx_hdr.plen     <= ARP_PLEN_IPV4;
            tx_hdr.oper     <= ARP_OPER_REQ;
            tx_hdr.src_mac  <= dev.mac;
            tx_hdr.src_ipv4 <= dev.ipv4;
            tx_hdr.dst_mac  <= MAC_BROADCAST;
            tx_hdr.dst_ipv4 <= look_ip;
            r_state         <= R_SEND;
          end
        end
        R_SEND: begin
          if (!tx_busy) begin
            send_req <= 1'b1;
            r_state  <= R_WAIT;
          end
        end
        R_WAIT: begin
          tmr <= tmr + 1'b1;
          if (learn_val && learn_entry.ipv4 == look_ip) begin
            rsp_mac <= learn_entry.mac;  // reply seen
            rsp_val <= 1'b1;
            r_state <= R_IDLE;
          end else if (tmr == TMR_LAST) begin
            rsp_err <= 1'b1;
            r_state <= R_IDLE;
          end
        end
        default: r_state <= R_IDLE;
      endcase
    end
  end

endmodule : arp_table

/* logic/arp_tx_serializer.sv */
`timescale 1ns/1ns

module arp_tx_serializer (
  input  logic              clk,
  input  logic              rst,
  input  arp_pkg::arp_hdr_t tx_hdr,
  input  logic              send_req,
  output logic              tx_busy,
  output logic [7:0]        tx_data,
  output logic              tx_val,
  output logic              tx_last
);

  import arp_pkg::*;

  localparam int         HDR_W     = $bits(arp_hdr_t);
  localparam logic [4:0] LAST_BYTE = 5'(ARP_HDR_BYTES - 1);

  logic [HDR_W-1:0] sr;       // header with the first byte in the top
  logic [4:0]       byte_cnt;
  logic             active;
  logic             start;

  assign start = send_req && !active;

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      byte_cnt <= '0;
    end else if (start) begin
      active   <= 1'b1;
      byte_cnt <= '0;
    end else if (active) begin
      byte_cnt <= byte_cnt + 1'b1;
      if (byte_cnt == LAST_BYTE) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sr <= tx_hdr;
    end else if (active) begin
      sr <= {sr[HDR_W-9:0], 8'h00};
    end
  end

  assign tx_data = sr[HDR_W-1 -: 8];
  assign tx_val  = active;
  // counter parks past the last byte between frames
  assign tx_last = byte_cnt == LAST_BYTE;

  // covers the send_req cycle too
  assign tx_busy = send_req || active;

endmodule : arp_tx_serializer

/* logic/arp_rx_filter.sv */
`timescale 1ns/1ns

module arp_rx_filter (
  input  logic                clk,
  input  logic                rst,
  input  arp_pkg::dev_t       dev,
  input  arp_pkg::arp_hdr_t   rx_hdr,
  input  logic                rx_hdr_val,
  output logic                learn_val,
  output arp_pkg::arp_entry_t learn_entry
);

  import arp_pkg::*;

  logic fmt_ok;
  logic oper_ok;
  logic accept;

  // ethernet/ipv4 flavour only
  assign fmt_ok = rx_hdr.hw_type == ARP_HW_ETH &&
                  rx_hdr.proto   == ARP_PROTO_IPV4 &&
                  rx_hdr.hlen    == ARP_HLEN_ETH &&
                  rx_hdr.plen    == ARP_PLEN_IPV4;

  assign oper_ok = rx_hdr.oper == ARP_OPER_REQ || rx_hdr.oper == ARP_OPER_REPLY;

  assign accept = rx_hdr_val && fmt_ok && oper_ok &&
                  rx_hdr.dst_ipv4 == dev.ipv4 &&  // must target us
                  rx_hdr.src_ipv4 != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      learn_val <= 1'b0;
    end else begin
      learn_val <= accept;
    end
  end

  // sender binding
  always_ff @(posedge clk) begin
    if (accept) begin
      learn_entry.valid <= 1'b1;
      learn_entry.ipv4  <= rx_hdr.src_ipv4;
      learn_entry.mac   <= rx_hdr.src_mac;
    end
  end

endmodule : arp_rx_filter

/* logic/arp_entry_ram.sv */
`timescale 1ns/1ns

module arp_entry_ram #(
  parameter int ADDR_W = 4
) (
  input  logic                [ADDR_W-1:0] addr_a,
  input  logic                             clk,
  input  logic                             we_a,
  input  arp_pkg::arp_entry_t              d_a,
  output arp_pkg::arp_entry_t              q_a,
  input  logic                [ADDR_W-1:0] addr_b,
  output arp_pkg::arp_entry_t              q_b
);

  import arp_pkg::*;

  arp_entry_t mem [2**ADDR_W];

  // port a reads before it writes
  always_ff @(posedge clk) begin
    if (we_a) begin
      mem[addr_a] <= d_a;
    end
    q_a <= mem[addr_a];
  end

  // port b is the read only lookup side
  always_ff @(posedge clk) begin
    q_b <= mem[addr_b];
  end

endmodule : arp_entry_ram

/* logic/arp_pkg.sv */
package arp_pkg;

  // byte 3 goes out first
  typedef logic [3:0][7:0] ipv4_t;

  // byte 5 goes out first
  typedef logic [5:0][7:0] mac_t;

  typedef struct packed {
    mac_t  mac;
    ipv4_t ipv4;
  } dev_t;

  // fields in wire order with the msb first
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_t        src_mac;
    ipv4_t       src_ipv4;
    mac_t        dst_mac;
    ipv4_t       dst_ipv4;
  } arp_hdr_t;

  typedef struct packed {
    logic  valid;
    ipv4_t ipv4;
    mac_t  mac;
  } arp_entry_t;

  localparam logic [15:0] ARP_HW_ETH     = 16'h0001;
  localparam logic [15:0] ARP_PROTO_IPV4 = 16'h0800;
  localparam logic [15:0] ARP_OPER_REQ   = 16'h0001;
  localparam logic [15:0] ARP_OPER_REPLY = 16'h0002;

  // address lengths carried in hlen/plen
  localparam logic [7:0] ARP_HLEN_ETH  = 8'd6;
  localparam logic [7:0] ARP_PLEN_IPV4 = 8'd4;

  localparam int ARP_HDR_BYTES = 28;

  localparam mac_t MAC_BROADCAST = '1;

endpackage : arp_pkg
